//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

    // Datapath and register index widths
    localparam int xlen          = 32;
    localparam int reg_addr_bits = 5;

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Instruction field bit ranges
    localparam int opcode_lsb = 0;
    localparam int opcode_msb = 6;

    localparam int rd_lsb     = 7;
    localparam int rd_msb     = 11;

    localparam int funct3_lsb = 12;
    localparam int funct3_msb = 14;

    localparam int rs1_lsb    = 15;
    localparam int rs1_msb    = 19;

    localparam int rs2_lsb    = 20;
    localparam int rs2_msb    = 24;

    localparam int funct7_lsb = 25; // Also the upper part of the S immediate
    localparam int funct7_msb = 31;

endpackage

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         redirect,
    input  wire  [core_pkg::xlen-1:0]   redirect_pc,
    output logic [core_pkg::xlen-1:0]   imem_addr,
    input  wire  [core_pkg::xlen-1:0]   imem_data,
    output logic                        if_valid,
    output logic [core_pkg::xlen-1:0]   if_pc,
    output logic [core_pkg::xlen-1:0]   if_instr
);

    logic [core_pkg::xlen-1:0] pc;
    logic [core_pkg::xlen-1:0] pc_next;

    assign imem_addr = pc; // Byte address, memory answers in the same cycle
    assign pc_next   = redirect ? redirect_pc : pc + core_pkg::xlen'(4);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc       <= '0;
            if_valid <= 1'b0;
        end
        else
        begin
            pc       <= pc_next;
            if_valid <= !redirect; // Word fetched behind a taken branch is dropped
        end
    end

    always_ff @(posedge clk)
    begin
        if_pc    <= pc;
        if_instr <= imem_data;
    end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 if_valid,
    input  wire  [core_pkg::xlen-1:0]           if_pc,
    input  wire  [core_pkg::xlen-1:0]           if_instr,
    input  wire                                 redirect,
    output logic [core_pkg::reg_addr_bits-1:0]  rs1_addr,
    output logic [core_pkg::reg_addr_bits-1:0]  rs2_addr,
    input  wire  [core_pkg::xlen-1:0]           rs1_data,
    input  wire  [core_pkg::xlen-1:0]           rs2_data,
    output logic                                ex_valid,
    output logic [core_pkg::xlen-1:0]           ex_pc,
    output logic [core_pkg::xlen-1:0]           ex_rs1_data,
    output logic [core_pkg::xlen-1:0]           ex_rs2_data,
    output logic [core_pkg::xlen-1:0]           ex_imm,
    output core_pkg::alu_op_e                   ex_alu_op,
    output logic                                ex_alu_src,
    output logic                                ex_branch,
    output logic                                ex_branch_ne,
    output logic                                ex_mem_read,
    output logic                                ex_mem_write,
    output logic                                ex_reg_write,
    output logic [core_pkg::reg_addr_bits-1:0]  ex_rd
);

    core_pkg::opcode_e                  opcode;
    core_pkg::alu_op_e                  alu_op;
    logic [core_pkg::reg_addr_bits-1:0] rd;
    logic [2:0]                         funct3;
    logic [6:0]                         funct7;
    logic [core_pkg::xlen-1:0]          imm_i;
    logic [core_pkg::xlen-1:0]          imm_s;
    logic [core_pkg::xlen-1:0]          imm_b;
    logic [core_pkg::xlen-1:0]          imm;
    logic                               known;
    logic                               alu_src;
    logic                               branch;
    logic                               mem_read;
    logic                               mem_write;
    logic                               reg_write;

    assign opcode   = core_pkg::opcode_e'(if_instr[core_pkg::opcode_msb:core_pkg::opcode_lsb]);
    assign rd       = if_instr[core_pkg::rd_msb:core_pkg::rd_lsb];
    assign funct3   = if_instr[core_pkg::funct3_msb:core_pkg::funct3_lsb];
    assign funct7   = if_instr[core_pkg::funct7_msb:core_pkg::funct7_lsb];
    assign rs1_addr = if_instr[core_pkg::rs1_msb:core_pkg::rs1_lsb];
    assign rs2_addr = if_instr[core_pkg::rs2_msb:core_pkg::rs2_lsb];

    // Sign-extended immediates, B form has an implicit zero LSB
    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, funct7, rd};
    assign imm_b = {{20{if_instr[31]}}, if_instr[7], if_instr[30:25], if_instr[11:8], 1'b0};

    always_comb
    begin
        known     = 1'b1;
        alu_op    = core_pkg::ALU_ADD;
        alu_src   = 1'b0;
        branch    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        imm       = imm_i;
        case (opcode)
            core_pkg::OP_REG:
            begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                    3'b010:  alu_op = core_pkg::ALU_SLT;
                    3'b100:  alu_op = core_pkg::ALU_XOR;
                    3'b110:  alu_op = core_pkg::ALU_OR;
                    3'b111:  alu_op = core_pkg::ALU_AND;
                    default: known  = 1'b0; // Shifts and SLTU not supported
                endcase
            end
            core_pkg::OP_IMM:
            begin
                alu_src   = 1'b1; // ADDI only
                reg_write = 1'b1;
            end
            core_pkg::OP_LOAD:
            begin
                alu_src   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            core_pkg::OP_STORE:
            begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                imm       = imm_s;
            end
            core_pkg::OP_BRANCH:
            begin
                branch = 1'b1;
                imm    = imm_b;
            end
            default: known = 1'b0;
        endcase
        if (rd == '0)
            reg_write = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_valid     <= 1'b0;
            ex_branch    <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end
        else
        begin
            ex_valid     <= if_valid && known && !redirect; // Unknown word becomes a bubble
            ex_branch    <= branch;
            ex_mem_read  <= mem_read;
            ex_mem_write <= mem_write;
            ex_reg_write <= reg_write;
        end
    end

    always_ff @(posedge clk)
    begin
        ex_pc        <= if_pc;
        ex_rs1_data  <= rs1_data;
        ex_rs2_data  <= rs2_data;
        ex_imm       <= imm;
        ex_alu_op    <= alu_op;
        ex_alu_src   <= alu_src;
        ex_branch_ne <= funct3[0]; // BNE is funct3 001
        ex_rd        <= rd;
    end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  [core_pkg::reg_addr_bits-1:0]  rs1_addr,
    input  wire  [core_pkg::reg_addr_bits-1:0]  rs2_addr,
    output logic [core_pkg::xlen-1:0]           rs1_data,
    output logic [core_pkg::xlen-1:0]           rs2_data,
    input  wire                                 wb_valid,
    input  wire  [core_pkg::reg_addr_bits-1:0]  wb_rd,
    input  wire  [core_pkg::xlen-1:0]           wb_data
);

    logic [core_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_valid)
            regs[wb_rd] <= wb_data;
    end

    // x0 always reads as zero
    assign rs1_data = (rs1_addr == '0)                  ? '0      :
                      (wb_valid && wb_rd == rs1_addr)   ? wb_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0)                  ? '0      :
                      (wb_valid && wb_rd == rs2_addr)   ? wb_data : regs[rs2_addr]; // Write-through

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 ex_valid,
    input  wire  [core_pkg::xlen-1:0]           ex_pc,
    input  wire  [core_pkg::xlen-1:0]           ex_rs1_data,
    input  wire  [core_pkg::xlen-1:0]           ex_rs2_data,
    input  wire  [core_pkg::xlen-1:0]           ex_imm,
    input  core_pkg::alu_op_e                   ex_alu_op,
    input  wire                                 ex_alu_src,
    input  wire                                 ex_branch,
    input  wire                                 ex_branch_ne,
    input  wire                                 ex_mem_read,
    input  wire                                 ex_mem_write,
    input  wire                                 ex_reg_write,
    input  wire  [core_pkg::reg_addr_bits-1:0]  ex_rd,
    output logic                                redirect,
    output logic [core_pkg::xlen-1:0]           redirect_pc,
    output logic                                mem_valid,
    output logic [core_pkg::xlen-1:0]           mem_alu_result,
    output logic [core_pkg::xlen-1:0]           mem_store_data,
    output logic                                mem_read,
    output logic                                mem_write,
    output logic                                mem_reg_write,
    output logic [core_pkg::reg_addr_bits-1:0]  mem_rd
);

    logic [core_pkg::xlen-1:0] operand_b;
    logic [core_pkg::xlen-1:0] alu_result;
    logic                      operands_equal;

    assign operand_b = ex_alu_src ? ex_imm : ex_rs2_data;

    always_comb
    begin
        case (ex_alu_op)
            core_pkg::ALU_SUB: alu_result = ex_rs1_data - operand_b;
            core_pkg::ALU_AND: alu_result = ex_rs1_data & operand_b;
            core_pkg::ALU_OR:  alu_result = ex_rs1_data | operand_b;
            core_pkg::ALU_XOR: alu_result = ex_rs1_data ^ operand_b;
            core_pkg::ALU_SLT:
                alu_result = {{(core_pkg::xlen-1){1'b0}},
                              $signed(ex_rs1_data) < $signed(operand_b)};
            default:           alu_result = ex_rs1_data + operand_b;
        endcase
    end

    // BEQ or BNE, target relative to the branch itself
    assign operands_equal = (ex_rs1_data == ex_rs2_data);
    assign redirect       = ex_valid && ex_branch && (operands_equal != ex_branch_ne);
    assign redirect_pc    = ex_pc + ex_imm;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_valid     <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
            mem_reg_write <= 1'b0;
        end
        else
        begin
            mem_valid     <= ex_valid;
            mem_read      <= ex_mem_read;
            mem_write     <= ex_mem_write;
            mem_reg_write <= ex_reg_write;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_alu_result <= alu_result; // Also the data address for loads and stores
        mem_store_data <= ex_rs2_data;
        mem_rd         <= ex_rd;
    end

endmodule

`default_nettype wire

//--- hw/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage #(
    parameter int dmem_words = 64
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 mem_valid,
    input  wire  [core_pkg::xlen-1:0]           mem_alu_result,
    input  wire  [core_pkg::xlen-1:0]           mem_store_data,
    input  wire                                 mem_read,
    input  wire                                 mem_write,
    input  wire                                 mem_reg_write,
    input  wire  [core_pkg::reg_addr_bits-1:0]  mem_rd,
    output logic                                wb_valid,
    output logic [core_pkg::reg_addr_bits-1:0]  wb_rd,
    output logic [core_pkg::xlen-1:0]           wb_data
);

    localparam int index_bits = $clog2(dmem_words);

    logic [core_pkg::xlen-1:0] ram [dmem_words];
    logic [index_bits-1:0]     word_index;
    logic [core_pkg::xlen-1:0] load_data;

    // Byte address to word index, upper bits wrap
    assign word_index = mem_alu_result[index_bits+1:2];
    assign load_data  = ram[word_index];

    always_ff @(posedge clk)
    begin
        if (mem_valid && mem_write)
            ram[word_index] <= mem_store_data;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= mem_valid && mem_reg_write;
    end

    always_ff @(posedge clk)
    begin
        wb_rd   <= mem_rd;
        wb_data <= mem_read ? load_data : mem_alu_result;
    end

endmodule

`default_nettype wire

//--- hw/pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core #(
    parameter int dmem_words = 64
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    output logic [core_pkg::xlen-1:0]           imem_addr,
    input  wire  [core_pkg::xlen-1:0]           imem_data,
    output logic                                wb_valid,
    output logic [core_pkg::reg_addr_bits-1:0]  wb_rd,
    output logic [core_pkg::xlen-1:0]           wb_data
);

    // IF/ID
    logic                               if_valid;
    logic [core_pkg::xlen-1:0]          if_pc;
    logic [core_pkg::xlen-1:0]          if_instr;

    // Register file read side
    logic [core_pkg::reg_addr_bits-1:0] rs1_addr;
    logic [core_pkg::reg_addr_bits-1:0] rs2_addr;
    logic [core_pkg::xlen-1:0]          rs1_data;
    logic [core_pkg::xlen-1:0]          rs2_data;

    // ID/EX
    logic                               ex_valid;
    logic [core_pkg::xlen-1:0]          ex_pc;
    logic [core_pkg::xlen-1:0]          ex_rs1_data;
    logic [core_pkg::xlen-1:0]          ex_rs2_data;
    logic [core_pkg::xlen-1:0]          ex_imm;
    core_pkg::alu_op_e                  ex_alu_op;
    logic                               ex_alu_src;
    logic                               ex_branch;
    logic                               ex_branch_ne;
    logic                               ex_mem_read;
    logic                               ex_mem_write;
    logic                               ex_reg_write;
    logic [core_pkg::reg_addr_bits-1:0] ex_rd;

    // Branch redirect from execute
    logic                               redirect;
    logic [core_pkg::xlen-1:0]          redirect_pc;

    // EX/MEM
    logic                               mem_valid;
    logic [core_pkg::xlen-1:0]          mem_alu_result;
    logic [core_pkg::xlen-1:0]          mem_store_data;
    logic                               mem_read;
    logic                               mem_write;
    logic                               mem_reg_write;
    logic [core_pkg::reg_addr_bits-1:0] mem_rd;

    fetch_stage fetch_stage_i (
        .clk(clk), .rst_n(rst_n),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr)
    );

    decode_stage decode_stage_i (
        .clk(clk), .rst_n(rst_n),
        .if_valid(if_valid), .if_pc(if_pc), .if_instr(if_instr),
        .redirect(redirect),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_valid(ex_valid), .ex_pc(ex_pc),
        .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
        .ex_imm(ex_imm), .ex_alu_op(ex_alu_op), .ex_alu_src(ex_alu_src),
        .ex_branch(ex_branch), .ex_branch_ne(ex_branch_ne),
        .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
        .ex_reg_write(ex_reg_write), .ex_rd(ex_rd)
    );

    register_file register_file_i (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    execute_stage execute_stage_i (
        .clk(clk), .rst_n(rst_n),
        .ex_valid(ex_valid), .ex_pc(ex_pc),
        .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
        .ex_imm(ex_imm), .ex_alu_op(ex_alu_op), .ex_alu_src(ex_alu_src),
        .ex_branch(ex_branch), .ex_branch_ne(ex_branch_ne),
        .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
        .ex_reg_write(ex_reg_write), .ex_rd(ex_rd),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .mem_valid(mem_valid), .mem_alu_result(mem_alu_result),
        .mem_store_data(mem_store_data), .mem_read(mem_read),
        .mem_write(mem_write), .mem_reg_write(mem_reg_write), .mem_rd(mem_rd)
    );

    memory_stage #(
        .dmem_words(dmem_words)
    ) memory_stage_i (
        .clk(clk), .rst_n(rst_n),
        .mem_valid(mem_valid), .mem_alu_result(mem_alu_result),
        .mem_store_data(mem_store_data), .mem_read(mem_read),
        .mem_write(mem_write), .mem_reg_write(mem_reg_write), .mem_rd(mem_rd),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int half_period  = 2, // 4 ns period
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1; // Released just after an edge
    end

endmodule

`default_nettype wire

//--- testbench/tb_pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_core;

    localparam int max_words = 256;
    localparam logic [core_pkg::xlen-1:0] nop_word = 32'h00000013; // ADDI x0, x0, 0

    logic                               clk;
    logic                               rst_n;
    logic [core_pkg::xlen-1:0]          imem_addr;
    logic [core_pkg::xlen-1:0]          imem_data;
    logic                               wb_valid;
    logic [core_pkg::reg_addr_bits-1:0] wb_rd;
    logic [core_pkg::xlen-1:0]          wb_data;

    // Program image and expected writebacks
    logic [core_pkg::xlen-1:0]          prog [max_words];
    int                                 num_words = 0;
    logic [core_pkg::reg_addr_bits-1:0] exp_rd[$];
    logic [core_pkg::xlen-1:0]          exp_value[$];
    string                              exp_name[$];
    string                              test_names[$];
    int                                 test_end[$]; // Entries used up once the test is done
    int                                 exp_total = 0;
    bit                                 stim_loaded = 1'b0;

    int next_exp     = 0;
    int cur_test     = 0;
    int checks       = 0;
    int errors       = 0;
    int test_errors  = 0;
    int tests_failed = 0;

    clock_gen clock_gen_i (
        .clk(clk),
        .rst_n(rst_n)
    );

    pipeline_core #(
        .dmem_words(64)
    ) pipeline_core_i (
        .clk(clk),
        .rst_n(rst_n),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .wb_valid(wb_valid),
        .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

    task automatic load_stimulus(output bit ok);
        int                        fd;
        string                     line;
        string                     name;
        int                        rd_num;
        logic [core_pkg::xlen-1:0] word;
        ok = 1'b0;
        fd = $fopen("testbench/core_stim.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0)
                    continue;
                case (line[0])
                    "I":
                    begin
                        void'($sscanf(line, "I %h", word));
                        prog[8'(num_words)] = word;
                        num_words++;
                    end
                    "W":
                    begin
                        void'($sscanf(line, "W %s %d %h", name, rd_num, word));
                        exp_name.push_back(name);
                        exp_rd.push_back(5'(rd_num));
                        exp_value.push_back(word);
                    end
                    "T":
                    begin
                        void'($sscanf(line, "T %s", name));
                        test_names.push_back(name);
                        test_end.push_back(exp_rd.size());
                    end
                    default: ; // Comments and blank lines
                endcase
            end
            $fclose(fd);
            exp_total = exp_rd.size();
            ok = 1'b1;
        end
    endtask

    task automatic report_finished_tests();
        int first;
        while (cur_test < test_end.size() && next_exp >= test_end[cur_test])
        begin
            first = (cur_test == 0) ? 0 : test_end[cur_test-1];
            if (test_errors == 0)
                $display("[PASS] %s (%0d writebacks)", test_names[cur_test],
                         test_end[cur_test] - first);
            else
            begin
                $display("[FAIL] %s (%0d of %0d writebacks wrong)", test_names[cur_test],
                         test_errors, test_end[cur_test] - first);
                tests_failed++;
            end
            test_errors = 0;
            cur_test++;
        end
    endtask

    task automatic check_writeback();
        assert (next_exp < exp_total)
        else
        begin
            $display("Unexpected writeback of x%0d = %h after the last expected one",
                     wb_rd, wb_data);
            errors++;
        end
        if (next_exp < exp_total)
        begin
            checks++;
            assert (wb_rd == exp_rd[next_exp] && wb_data == exp_value[next_exp])
            else
            begin
                $display("[FAIL] %s: expected x%0d = %h, actual x%0d = %h",
                         exp_name[next_exp], exp_rd[next_exp], exp_value[next_exp],
                         wb_rd, wb_data);
                errors++;
                test_errors++;
            end
            next_exp++;
            report_finished_tests();
        end
    endtask

    // Instruction memory answers a little after each edge
    initial
    begin : drive_fetch
        imem_data = nop_word;
        forever
        begin
            @(posedge clk);
            #1;
            if (imem_addr[31:2] < 30'(num_words))
                imem_data = prog[imem_addr[9:2]];
            else
                imem_data = nop_word;
        end
    end

    // Writeback port sampled mid-cycle
    always @(negedge clk)
    begin
        if (rst_n && wb_valid)
            check_writeback();
    end

    initial
    begin : main
        bit ok;
        load_stimulus(ok);
        if (!ok)
        begin
            $display("Cannot open the stimulus file testbench/core_stim.txt");
            $display("TEST RESULT: FAIL");
            $finish;
        end
        else
        begin
            $display("Loaded %0d program words, %0d expected writebacks, %0d tests",
                     num_words, exp_total, test_names.size());
            stim_loaded = 1'b1;
            wait (rst_n);
            wait (next_exp == exp_total);
            repeat (8) @(posedge clk); // Room for stray writebacks
            $display("Tests: %0d done, %0d failed; writebacks checked: %0d, errors: %0d",
                     cur_test, tests_failed, checks, errors);
            if (errors == 0 && exp_total != 0 && cur_test == test_names.size())
                $display("TEST RESULT: PASS");
            else
            begin
                if (exp_total == 0)
                    $display("The stimulus file holds no expected writebacks");
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

    // Limit of (program words + 20) * 4 cycles
    initial
    begin : watchdog
        wait (stim_loaded);
        repeat ((num_words + 20) * 4) @(posedge clk);
        $display("Timeout: %0d of %0d expected writebacks never appeared",
                 exp_total - next_exp, exp_total);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hw/core_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/register_file.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/pipeline_core.sv
testbench/clock_gen.sv
testbench/tb_pipeline_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it into a log and look for the pass line

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pipeline_core --Mdir "$build_dir" -o sim_tb -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/sim_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$log_file"; then
    exit 0
else
    echo "Pass line not found in $log_file"
    exit 1
fi

//--- testbench/core_stim.txt
# I <word hex>: program word, from address 0 upwards
# W <test> <rd> <value hex>: expected writeback in retirement order; T <test>: end of a test
I 00c00093 addi x1, x0, 12
I 00a00113 addi x2, x0, 10
I 00000013 nop
I 00000013 nop
I 002081b3 add x3, x1, x2
I 40208233 sub x4, x1, x2
I 0020f2b3 and x5, x1, x2
I 0020e333 or x6, x1, x2
I 0020c3b3 xor x7, x1, x2
I ffb00413 addi x8, x0, -5
I 00300493 addi x9, x0, 3
I 00000013 nop
I 00000013 nop
I 00942533 slt x10, x8, x9
I 0084a5b3 slt x11, x9, x8
I ff940613 addi x12, x8, -7
I 00302423 sw x3, 8(x0)
I 00702623 sw x7, 12(x0)
I 00802683 lw x13, 8(x0)
I 00c02703 lw x14, 12(x0)
I 00402423 sw x4, 8(x0)
I 00802783 lw x15, 8(x0)
I 00c02803 lw x16, 12(x0)
I 00108663 beq x1, x1, +12
I 00100893 addi x17, x0, 1 (flushed)
I 00200913 addi x18, x0, 2 (flushed)
I 00300993 addi x19, x0, 3
I 00109463 bne x1, x1, +8 (not taken)
I 00400a13 addi x20, x0, 4
I 00500a93 addi x21, x0, 5
I 00600b13 addi x22, x0, 6
I 06308013 addi x0, x1, 99
I 00200bb3 add x23, x0, x2
I 00048c33 add x24, x9, x0
W arith 1 0000000c
W arith 2 0000000a
W arith 3 00000016
W arith 4 00000002
W arith 5 00000008
W arith 6 0000000e
W arith 7 00000006
T arith
W signed 8 fffffffb
W signed 9 00000003
W signed 10 00000001
W signed 11 00000000
W signed 12 fffffff4
T signed
W memory 13 00000016
W memory 14 00000006
W memory 15 00000002
W memory 16 00000006
T memory
W beq_taken 19 00000003
T beq_taken
W bne_not_taken 20 00000004
W bne_not_taken 21 00000005
W bne_not_taken 22 00000006
T bne_not_taken
W x0_write 23 0000000a
W x0_write 24 00000003
T x0_write
